//--- rc5Pkg.sv
package rc5Pkg;

    //////////////////////////////////////////////////////////////////////
    // Cipher sizing
    //////////////////////////////////////////////////////////////////////

    localparam int DEFAULT_ROUNDS = 12;
    localparam int TABLE_WORDS    = 2 * DEFAULT_ROUNDS + 2;

    // Rotate amount is the low 5 bits of a word
    localparam int ROT_BITS = 5;

    typedef logic [31:0] rc5Word;

    // A is the upper word, B the lower
    typedef struct packed {
        rc5Word a;
        rc5Word b;
    } rc5Block;

    typedef logic [127:0] rc5Key;

    typedef rc5Word [TABLE_WORDS-1:0] roundKeyTable;

    // Key table magic constants
    localparam rc5Word P32 = 32'hB7E15163;
    localparam rc5Word Q32 = 32'h9E3779B9;

    //////////////////////////////////////////////////////////////////////
    // Word rotates
    //////////////////////////////////////////////////////////////////////

    function automatic rc5Word rotLeft(input rc5Word x, input logic [ROT_BITS-1:0] amt);
        logic [63:0] dbl;
        dbl = {x, x} << amt;
        return dbl[63:32];
    endfunction

    function automatic rc5Word rotRight(input rc5Word x, input logic [ROT_BITS-1:0] amt);
        logic [63:0] dbl;
        dbl = {x, x} >> amt;
        return dbl[31:0];
    endfunction

endpackage

//--- ctrlPkg.sv
package ctrlPkg;

    import rc5Pkg::*;

    typedef enum logic {
        OP_ENCRYPT = 1'b0,
        OP_DECRYPT = 1'b1
    } cipherOp;

    // Full request as seen on the outside port
    typedef struct packed {
        cipherOp op;
        rc5Key   key;
        rc5Block block;
    } cipherReq;

    // Request minus the key, handed to the round engine
    typedef struct packed {
        cipherOp op;
        rc5Block block;
    } cipherJob;

    typedef enum logic [1:0] {
        DEC_IDLE,
        DEC_EXPAND,
        DEC_BUSY
    } decodeState;

    typedef enum logic [2:0] {
        ENG_IDLE,
        ENG_WHITEN_IN,
        ENG_ROUND,
        ENG_WHITEN_OUT,
        ENG_DONE
    } engineState;

endpackage

//--- cmdDecode.sv
`timescale 1ns/1ps

module cmdDecode import rc5Pkg::*, ctrlPkg::*; (
    input  logic     clk,
    input  logic     clr,
    input  logic     i_req,
    input  cipherReq i_cmd,
    input  logic     i_released,
    output logic     o_startKey,
    output rc5Key    o_key,
    output cipherJob o_job
);

    decodeState state;
    logic       accept;

    // Only an idle decoder takes a new request
    assign accept = (state == DEC_IDLE) && i_req;

    //////////////////////////////////////////////////////////////////////
    // Request FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge clr) begin
        if (clr) begin
            state <= DEC_IDLE;
        end else begin
            case (state)
                DEC_IDLE: begin
                    if (accept) begin
                        state <= DEC_EXPAND;
                    end
                end
                DEC_EXPAND: begin
                    state <= DEC_BUSY;
                end
                DEC_BUSY: begin
                    // Held here until the handshake has fully returned to zero
                    if (i_released) begin
                        state <= DEC_IDLE;
                    end
                end
                default: begin
                    state <= DEC_IDLE;
                end
            endcase
        end
    end

    // One-cycle start pulse, key already latched
    assign o_startKey = (state == DEC_EXPAND);

    // Latched request split into key and job
    always_ff @(posedge clk) begin
        if (accept) begin
            o_key       <= i_cmd.key;
            o_job.op    <= i_cmd.op;
            o_job.block <= i_cmd.block;
        end
    end

endmodule

//--- keySchedule.sv
`timescale 1ns/1ps

module keySchedule import rc5Pkg::*; #(
    parameter int NUM_ROUNDS = 12,
    parameter int KEY_WORDS  = 4
) (
    input  logic         clk,
    input  logic         clr,
    input  logic         i_startKey,
    input  rc5Key        i_key,
    output logic         o_keysDone,
    output roundKeyTable o_roundKeys
);

    localparam int TBL       = 2 * NUM_ROUNDS + 2;
    localparam int MIX_STEPS = 3 * ((TBL > KEY_WORDS) ? TBL : KEY_WORDS);
    localparam int I_BITS    = $clog2(TBL);
    localparam int J_BITS    = (KEY_WORDS > 1) ? $clog2(KEY_WORDS) : 1;
    localparam int CNT_BITS  = $clog2(MIX_STEPS);

    roundKeyTable        sReg;
    rc5Word              lReg [KEY_WORDS];
    rc5Word              aReg;
    rc5Word              bReg;
    logic [I_BITS-1:0]   iIdx;
    logic [J_BITS-1:0]   jIdx;
    logic [CNT_BITS-1:0] stepCnt;
    logic                busy;

    logic [I_BITS-1:0]   iCur;
    logic [J_BITS-1:0]   jCur;
    rc5Word              sIn;
    rc5Word              lIn;
    rc5Word              aIn;
    rc5Word              bIn;
    rc5Word              aNew;
    rc5Word              abSum;
    rc5Word              bNew;

    if (NUM_ROUNDS != DEFAULT_ROUNDS) begin : gRoundsCheck
        $error("keySchedule: NUM_ROUNDS differs from rc5Pkg::DEFAULT_ROUNDS");
    end

    //////////////////////////////////////////////////////////////////////
    // Mix step
    //////////////////////////////////////////////////////////////////////

    // On start the first step runs straight from the initial table and key
    always_comb begin
        iCur  = i_startKey ? '0 : iIdx;
        jCur  = i_startKey ? '0 : jIdx;
        sIn   = i_startKey ? P32 : sReg[iCur];
        lIn   = i_startKey ? i_key[31:0] : lReg[jCur];
        aIn   = i_startKey ? '0 : aReg;
        bIn   = i_startKey ? '0 : bReg;
        aNew  = rotLeft(sIn + aIn + bIn, ROT_BITS'(3));
        abSum = aNew + bIn;
        bNew  = rotLeft(lIn + abSum, abSum[ROT_BITS-1:0]);
    end

    // Step counter and table indices
    always_ff @(posedge clk or posedge clr) begin
        if (clr) begin
            iIdx       <= '0;
            jIdx       <= '0;
            stepCnt    <= '0;
            busy       <= 1'b0;
            o_keysDone <= 1'b0;
        end else begin
            o_keysDone <= 1'b0;
            if (i_startKey || busy) begin
                iIdx    <= (iCur == I_BITS'(TBL - 1)) ? '0 : iCur + 1'b1;
                jIdx    <= (jCur == J_BITS'(KEY_WORDS - 1)) ? '0 : jCur + 1'b1;
                stepCnt <= i_startKey ? CNT_BITS'(1) : stepCnt + 1'b1;
                busy    <= 1'b1;
                if (!i_startKey && stepCnt == CNT_BITS'(MIX_STEPS - 1)) begin
                    busy       <= 1'b0;
                    o_keysDone <= 1'b1;
                end
            end
        end
    end

    // S and L tables plus the running A and B
    always_ff @(posedge clk) begin
        if (i_startKey) begin
            for (int k = 1; k < TBL; k++) begin
                sReg[k] <= P32 + Q32 * rc5Word'(k);
            end
            for (int k = 1; k < KEY_WORDS; k++) begin
                lReg[k] <= i_key[32*k +: 32];
            end
        end
        if (i_startKey || busy) begin
            sReg[iCur] <= aNew;
            lReg[jCur] <= bNew;
            aReg       <= aNew;
            bReg       <= bNew;
        end
    end

    assign o_roundKeys = sReg;

    // Decoder must wait for a finished table before starting another
    aNoRestart: assert property (@(posedge clk) disable iff (clr) busy |-> !i_startKey)
        else $error("keySchedule: startKey while key mix in progress");

endmodule

//--- roundEngine.sv
`timescale 1ns/1ps

module roundEngine import rc5Pkg::*, ctrlPkg::*; #(
    parameter int NUM_ROUNDS = 12
) (
    input  logic         clk,
    input  logic         clr,
    input  logic         i_keysDone,
    input  roundKeyTable i_roundKeys,
    input  cipherJob     i_job,
    output logic         o_blockDone,
    output rc5Block      o_result
);

    localparam int CNT_BITS = $clog2(NUM_ROUNDS + 1);

    engineState          state;
    logic [CNT_BITS-1:0] round;
    rc5Block             ab;
    logic                isEnc;
    rc5Word              sEven;
    rc5Word              sOdd;
    rc5Word              encA;
    rc5Word              encB;
    rc5Word              decA;
    rc5Word              decB;

    if (NUM_ROUNDS != DEFAULT_ROUNDS) begin : gRoundsCheck
        $error("roundEngine: NUM_ROUNDS differs from rc5Pkg::DEFAULT_ROUNDS");
    end

    assign isEnc = (i_job.op == OP_ENCRYPT);

    //////////////////////////////////////////////////////////////////////
    // Round datapath
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        sEven = i_roundKeys[2 * round];
        sOdd  = i_roundKeys[2 * round + 1];
        // Forward round
        encA  = rotLeft(ab.a ^ ab.b, ab.b[ROT_BITS-1:0]) + sEven;
        encB  = rotLeft(ab.b ^ encA, encA[ROT_BITS-1:0]) + sOdd;
        // Inverse round, B first
        decB  = rotRight(ab.b - sOdd, ab.a[ROT_BITS-1:0]) ^ ab.a;
        decA  = rotRight(ab.a - sEven, decB[ROT_BITS-1:0]) ^ decB;
    end

    // Encrypt counts rounds up, decrypt counts down
    always_ff @(posedge clk or posedge clr) begin
        if (clr) begin
            state <= ENG_IDLE;
            round <= '0;
        end else begin
            case (state)
                ENG_IDLE: begin
                    if (i_keysDone) begin
                        state <= isEnc ? ENG_WHITEN_IN : ENG_ROUND;
                        round <= isEnc ? CNT_BITS'(1) : CNT_BITS'(NUM_ROUNDS);
                    end
                end
                ENG_WHITEN_IN: begin
                    state <= ENG_ROUND;
                end
                ENG_ROUND: begin
                    if (isEnc) begin
                        if (round == CNT_BITS'(NUM_ROUNDS)) begin
                            state <= ENG_DONE;
                        end else begin
                            round <= round + 1'b1;
                        end
                    end else begin
                        if (round == CNT_BITS'(1)) begin
                            state <= ENG_WHITEN_OUT;
                        end else begin
                            round <= round - 1'b1;
                        end
                    end
                end
                ENG_WHITEN_OUT: begin
                    state <= ENG_DONE;
                end
                default: begin
                    state <= ENG_IDLE;
                end
            endcase
        end
    end

    // Block register, loaded from the job once keys are ready
    always_ff @(posedge clk) begin
        case (state)
            ENG_IDLE: begin
                if (i_keysDone) begin
                    ab <= i_job.block;
                end
            end
            ENG_WHITEN_IN: begin
                ab.a <= ab.a + i_roundKeys[0];
                ab.b <= ab.b + i_roundKeys[1];
            end
            ENG_ROUND: begin
                ab.a <= isEnc ? encA : decA;
                ab.b <= isEnc ? encB : decB;
            end
            ENG_WHITEN_OUT: begin
                ab.a <= ab.a - i_roundKeys[0];
                ab.b <= ab.b - i_roundKeys[1];
            end
            default: begin
            end
        endcase
    end

    assign o_blockDone = (state == ENG_DONE);
    assign o_result    = ab;

    aRoundRange: assert property (@(posedge clk) disable iff (clr)
        state == ENG_ROUND |-> (round >= CNT_BITS'(1) && round <= CNT_BITS'(NUM_ROUNDS)))
        else $error("roundEngine: round counter out of range");

endmodule

//--- resultStage.sv
`timescale 1ns/1ps

module resultStage import rc5Pkg::*; (
    input  logic    clk,
    input  logic    clr,
    input  logic    i_blockDone,
    input  rc5Block i_result,
    input  logic    i_req,
    output logic    o_ack,
    output rc5Block o_result,
    output logic    o_released
);

    logic ackDly;

    //////////////////////////////////////////////////////////////////////
    // Four-phase acknowledge
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge clr) begin
        if (clr) begin
            o_ack      <= 1'b0;
            ackDly     <= 1'b0;
            o_released <= 1'b0;
        end else begin
            ackDly <= o_ack;
            // Release the decoder the cycle after ack has dropped
            o_released <= ackDly && !o_ack;
            if (i_blockDone) begin
                o_ack <= 1'b1;
            end else if (o_ack && !i_req) begin
                o_ack <= 1'b0;
            end
        end
    end

    // Result held for the whole ack phase
    always_ff @(posedge clk) begin
        if (i_blockDone) begin
            o_result <= i_result;
        end
    end

    // Master still holding req keeps ack up and the result steady
    aAckHold: assert property (@(posedge clk) disable iff (clr)
        o_ack && i_req |=> o_ack && $stable(o_result))
        else $error("resultStage: ack dropped or result changed while req high");

endmodule

//--- rc5Top.sv
`timescale 1ns/1ps

module rc5Top import rc5Pkg::*, ctrlPkg::*; #(
    parameter int NUM_ROUNDS = 12,
    parameter int KEY_WORDS  = 4
) (
    input  logic     clk,
    input  logic     clr,
    input  logic     i_req,
    input  cipherReq i_cmd,
    output logic     o_ack,
    output rc5Block  o_result
);

    logic         startKey;
    rc5Key        key;
    cipherJob     job;
    logic         keysDone;
    roundKeyTable roundKeys;
    logic         blockDone;
    rc5Block      engResult;
    logic         released;

    //////////////////////////////////////////////////////////////////////
    // Decode, key schedule, rounds, result
    //////////////////////////////////////////////////////////////////////

    cmdDecode uDecode (
        .clk        (clk),
        .clr        (clr),
        .i_req      (i_req),
        .i_cmd      (i_cmd),
        .i_released (released),
        .o_startKey (startKey),
        .o_key      (key),
        .o_job      (job)
    );

    keySchedule #(
        .NUM_ROUNDS (NUM_ROUNDS),
        .KEY_WORDS  (KEY_WORDS)
    ) uKeys (
        .clk         (clk),
        .clr         (clr),
        .i_startKey  (startKey),
        .i_key       (key),
        .o_keysDone  (keysDone),
        .o_roundKeys (roundKeys)
    );

    roundEngine #(
        .NUM_ROUNDS (NUM_ROUNDS)
    ) uEngine (
        .clk         (clk),
        .clr         (clr),
        .i_keysDone  (keysDone),
        .i_roundKeys (roundKeys),
        .i_job       (job),
        .o_blockDone (blockDone),
        .o_result    (engResult)
    );

    resultStage uResult (
        .clk         (clk),
        .clr         (clr),
        .i_blockDone (blockDone),
        .i_result    (engResult),
        .i_req       (i_req),
        .o_ack       (o_ack),
        .o_result    (o_result),
        .o_released  (released)
    );

endmodule

//--- tbRc5.sv
`timescale 1ns/1ps

module tbRc5 import rc5Pkg::*, ctrlPkg::*; ();

    localparam int ROUNDS    = 12;
    localparam int TBL       = 2 * ROUNDS + 2;
    localparam int KEY_WORDS = 4;
    localparam int MIX_STEPS = 3 * TBL;
    localparam int TIMEOUT   = 300;
    localparam int NUM_RAND  = 50;

    // Expected values for one request
    typedef struct packed {
        rc5Block refBlk;
        rc5Block origBlk;
        logic    chkOrig;
    } expEntry;

    logic     clk;
    logic     clr;
    logic     i_req;
    cipherReq i_cmd;
    logic     o_ack;
    rc5Block  o_result;

    expEntry  expQ[$];
    int       checkedCount = 0;
    int       sentCount    = 0;
    int       errCount     = 0;

    rc5Key    keys[NUM_RAND];
    rc5Block  plain[NUM_RAND];
    rc5Block  cipher[NUM_RAND];

    rc5Top #(
        .NUM_ROUNDS (ROUNDS),
        .KEY_WORDS  (KEY_WORDS)
    ) UUT (
        .clk      (clk),
        .clr      (clr),
        .i_req    (i_req),
        .i_cmd    (i_cmd),
        .o_ack    (o_ack),
        .o_result (o_result)
    );

    initial begin
        clk = 1'b0;
    end

    always #50 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    function automatic rc5Word wordRol(input rc5Word x, input int n);
        return (n == 0) ? x : ((x << n) | (x >> (32 - n)));
    endfunction

    function automatic rc5Word wordRor(input rc5Word x, input int n);
        return (n == 0) ? x : ((x >> n) | (x << (32 - n)));
    endfunction

    function automatic roundKeyTable expandKey(input rc5Key key);
        rc5Word       s[TBL];
        rc5Word       l[KEY_WORDS];
        rc5Word       a;
        rc5Word       b;
        int           i;
        int           j;
        roundKeyTable tbl;
        s[0] = P32;
        for (int k = 1; k < TBL; k++) begin
            s[k] = s[k-1] + Q32;
        end
        for (int k = 0; k < KEY_WORDS; k++) begin
            l[k] = key[32*k +: 32];
        end
        a = '0;
        b = '0;
        i = 0;
        j = 0;
        for (int k = 0; k < MIX_STEPS; k++) begin
            a    = wordRol(s[i] + a + b, 3);
            s[i] = a;
            b    = wordRol(l[j] + a + b, int'((a + b) & 32'd31));
            l[j] = b;
            i    = (i + 1) % TBL;
            j    = (j + 1) % KEY_WORDS;
        end
        for (int k = 0; k < TBL; k++) begin
            tbl[k] = s[k];
        end
        return tbl;
    endfunction

    function automatic rc5Block rc5Ref(input cipherReq req);
        roundKeyTable s;
        rc5Word       a;
        rc5Word       b;
        rc5Block      res;
        s = expandKey(req.key);
        a = req.block.a;
        b = req.block.b;
        if (req.op == OP_ENCRYPT) begin
            a = a + s[0];
            b = b + s[1];
            for (int r = 1; r <= ROUNDS; r++) begin
                a = wordRol(a ^ b, int'(b[4:0])) + s[2*r];
                b = wordRol(b ^ a, int'(a[4:0])) + s[2*r+1];
            end
        end else begin
            for (int r = ROUNDS; r >= 1; r--) begin
                b = wordRor(b - s[2*r+1], int'(a[4:0])) ^ a;
                a = wordRor(a - s[2*r], int'(b[4:0])) ^ b;
            end
            b = b - s[1];
            a = a - s[0];
        end
        res.a = a;
        res.b = b;
        return res;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Checks and waits
    //////////////////////////////////////////////////////////////////////

    task automatic failRun(input string msg);
        errCount++;
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic checkBlock(input string name, input rc5Block got, input rc5Block exp);
        if (got !== exp) begin
            failRun($sformatf("FAILED time=%0t signal=%s got=%h expected=%h",
                              $time, name, got, exp));
        end
    endtask

    task automatic checkAck(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            failRun($sformatf("FAILED time=%0t signal=%s got=%b expected=%b",
                              $time, name, got, exp));
        end
    endtask

    // Returns on the falling edge where o_ack has the wanted level
    task automatic waitAck(input logic level);
        int cnt;
        cnt = 0;
        @(negedge clk);
        while (o_ack !== level) begin
            cnt++;
            if (cnt > TIMEOUT) begin
                failRun($sformatf("Timeout: o_ack did not go to %0b within %0d cycles",
                                  level, TIMEOUT));
            end
            @(negedge clk);
        end
    endtask

    // One full four-phase request with req held for hold cycles after ack
    task automatic runRequest(input cipherOp op, input rc5Key key, input rc5Block blk,
                              input rc5Block orig, input logic chkOrig, input int hold,
                              output rc5Block got);
        cipherReq cmd;
        expEntry  exp;
        rc5Block  held;
        cmd.op      = op;
        cmd.key     = key;
        cmd.block   = blk;
        exp.refBlk  = rc5Ref(cmd);
        exp.origBlk = orig;
        exp.chkOrig = chkOrig;
        @(posedge clk);
        i_req <= 1'b1;
        i_cmd <= cmd;
        expQ.push_back(exp);
        sentCount++;
        waitAck(1'b1);
        held = o_result;
        for (int k = 0; k < hold; k++) begin
            @(negedge clk);
            checkAck("o_ack", o_ack, 1'b1);
            checkBlock("o_result", o_result, exp.refBlk);
        end
        @(posedge clk);
        i_req <= 1'b0;
        waitAck(1'b0);
        got = held;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Compare process
    //////////////////////////////////////////////////////////////////////

    initial begin : compareProc
        expEntry exp;
        int      idle;
        forever begin
            idle = 0;
            @(negedge clk);
            while (expQ.size() == 0) begin
                idle++;
                if (idle > TIMEOUT) begin
                    failRun("Timeout: no request was issued to the DUT");
                end
                @(negedge clk);
            end
            exp = expQ.pop_front();
            waitAck(1'b1);
            checkBlock("o_result", o_result, exp.refBlk);
            if (exp.chkOrig) begin
                checkBlock("o_result", o_result, exp.origBlk);
            end
            checkedCount++;
            waitAck(1'b0);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin : stimulus
        rc5Block  got;
        rc5Block  zero;
        rc5Block  kat;
        cipherReq zeroReq;
        int       cnt;
        clr   = 1'b1;
        i_req = 1'b0;
        i_cmd = '0;
        zero  = '0;
        void'($urandom(32'h3e1ea056));

        // Known answer for the all-zero key and block
        zeroReq = '0;
        kat.a   = 32'hEEDBA521;
        kat.b   = 32'h6D8F4B15;
        checkBlock("rc5Ref", rc5Ref(zeroReq), kat);

        repeat (2) @(posedge clk);
        clr <= 1'b0;

        // Quiet after reset
        repeat (20) begin
            @(negedge clk);
            checkAck("o_ack", o_ack, 1'b0);
        end

        runRequest(OP_ENCRYPT, '0, zero, zero, 1'b0, 0, got);

        // Random encrypts with a short random hold
        for (int n = 0; n < NUM_RAND; n++) begin
            keys[n]  = {$urandom, $urandom, $urandom, $urandom};
            plain[n] = {$urandom, $urandom};
            runRequest(OP_ENCRYPT, keys[n], plain[n], plain[n], 1'b0,
                       int'($urandom % 4), cipher[n]);
        end

        // Decrypt back to the plaintext
        for (int n = 0; n < NUM_RAND; n++) begin
            runRequest(OP_DECRYPT, keys[n], cipher[n], plain[n], 1'b1,
                       int'($urandom % 4), got);
        end

        // Long back-pressure and then a request right behind it
        runRequest(OP_ENCRYPT, {$urandom, $urandom, $urandom, $urandom},
                   {$urandom, $urandom}, zero, 1'b0, 5 + int'($urandom % 11), got);
        runRequest(OP_ENCRYPT, keys[0], plain[0], plain[0], 1'b0, 0, got);

        cnt = 0;
        while (checkedCount < sentCount) begin
            cnt++;
            if (cnt > TIMEOUT) begin
                failRun("Timeout: compare process did not check every request");
            end
            @(negedge clk);
        end

        if (errCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- tb.f
rc5Pkg.sv
ctrlPkg.sv
cmdDecode.sv
keySchedule.sv
roundEngine.sv
resultStage.sv
rc5Top.sv
tbRc5.sv

//--- Bender.yml
package:
  name: rc5

sources:
  - rc5Pkg.sv
  - ctrlPkg.sv
  - cmdDecode.sv
  - keySchedule.sv
  - roundEngine.sv
  - resultStage.sv
  - rc5Top.sv
  - target: test
    files:
      - tbRc5.sv
